//--- flist.f
+incdir+hw
hw/adc_pkg.sv
hw/adc_cfg_regs.sv
hw/slice_sync.sv
hw/slice_quantizer.sv
hw/adc_output_merge.sv
hw/ti_adc_top.sv
tb/ti_adc_props.sv
tb/tb_ti_adc.sv

//--- Makefile
SRCS := $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_ti_adc
	./obj_dir/Vtb_ti_adc 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log || \
	    ! grep -q "Simulation completed successfully" sim.log; then \
	    echo "FAIL"; exit 1; \
	fi
	@echo "PASS"

obj_dir/Vtb_ti_adc: flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_ti_adc

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_ti_adc.sv
// testbench for the interleaved ADC back end with stimulus table, reference model and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module tb_ti_adc import adc_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int N_ENTRY    = 6;

    // one table row, gains listed slice 3 first
    typedef struct packed {
        logic [3:0]      en;
        logic [3:0]      on;
        logic [7:0]      phase;
        logic [3:0][7:0] gain;
        int              count;
        logic            rnd;
    } entry_t;

    localparam entry_t STIM [N_ENTRY] = '{
        '{4'hf, 4'h0, 8'he4, {8'd64, 8'd64, 8'd64, 8'd64}, 24, 1'b0},
        '{4'hf, 4'h0, 8'he4, {8'd255, 8'd128, 8'd32, 8'd64}, 24, 1'b0},
        // slice 2 frozen
        '{4'hf, 4'h4, 8'he4, {8'd64, 8'd64, 8'd64, 8'd64}, 16, 1'b0},
        // slice 1 disabled
        '{4'hd, 4'h0, 8'he4, {8'd64, 8'd64, 8'd64, 8'd64}, 16, 1'b0},
        // slices 0 and 1 share phase 0
        '{4'hf, 4'h0, 8'he0, {8'd64, 8'd64, 8'd64, 8'd64}, 16, 1'b0},
        '{4'hf, 4'h0, 8'he4, {8'd200, 8'd48, 8'd96, 8'd64}, 200, 1'b1}
    };

    logic        clk_adder;
    logic        rstb;
    adc_sample_t sample;
    logic        en_sync_in;
    logic        cfg_wr;
    cfg_addr_e   cfg_addr;
    logic [15:0] cfg_wdata;
    logic        en_sync_out;
    adc_out_t    adc_out;
    logic        collision;

    // reference model state
    logic [3:0]      m_en;
    logic [3:0]      m_on;
    logic [3:0][1:0] m_phase;
    logic [3:0][7:0] m_gain;
    logic [3:0][1:0] m_cnt;
    logic            m_q1;
    logic            m_q2;
    adc_out_t        exp_out [$];
    logic            exp_coll [$];

    ti_adc_top u_ti_adc_top (
        .clk_adder   (clk_adder),
        .rstb        (rstb),
        .sample      (sample),
        .en_sync_in  (en_sync_in),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .en_sync_out (en_sync_out),
        .adc_out     (adc_out),
        .collision   (collision)
    );

    initial begin
        clk_adder = 1'b0;
        forever #(CLK_PERIOD / 2) clk_adder = ~clk_adder;
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_result(input string name, input slice_result_t got,
                                input slice_result_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // index and result only matter on a valid word
    task automatic check_out(input adc_out_t got, input adc_out_t exp);
        check_bit("adc_out.valid", got.valid, exp.valid);
        if (exp.valid) begin
            if (got.idx !== exp.idx) begin
                $display("Error: adc_out.idx got 0x%h expected 0x%h", got.idx, exp.idx);
                abort_run();
            end
            check_result("adc_out.result", got.result, exp.result);
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic slice_result_t expected_result(input adc_sample_t s,
                                                      input logic [7:0] g);
        slice_result_t r;
        int            diff;
        int            scaled;
        r.sign = (s.vin_p >= s.vin_n);
        diff   = r.sign ? int'(s.vin_p) - int'(s.vin_n) : int'(s.vin_n) - int'(s.vin_p);
        scaled = (diff * int'(g)) >> `ADC_GAIN_SHIFT;
        r.mag  = (scaled > 127) ? 7'd127 : 7'(scaled);
        return r;
    endfunction

    // equal pair, clamping pair, negative pair, small ramp
    // kind shifts by one each round so every slice sees each pair
    function automatic adc_sample_t fixed_sample(input int k);
        adc_sample_t s;
        case ((k + k / 4) % 4)
            0: s = '{vin_p: 12'h123, vin_n: 12'h123};
            1: s = '{vin_p: 12'h800, vin_n: 12'h100};
            2: s = '{vin_p: 12'h100, vin_n: 12'h140};
            default: s = '{vin_p: 12'h200 + 12'(k), vin_n: 12'h200};
        endcase
        return s;
    endfunction

    function automatic adc_sample_t random_sample();
        adc_sample_t s;
        s.vin_p = 12'($urandom);
        s.vin_n = s.vin_p ^ 12'($urandom & 32'hff);
        return s;
    endfunction

    function automatic logic [15:0] write_data(input entry_t e, input int k);
        case (k)
            0: return {8'h00, e.on, e.en};
            1: return {8'h00, e.phase};
            default: return {8'h00, e.gain[k-2]};
        endcase
    endfunction

    function automatic int total_samples();
        int sum;
        sum = 0;
        for (int t = 0; t < N_ENTRY; t++) begin
            sum += STIM[t].count;
        end
        return sum;
    endfunction

    // one clock: check, drive, predict, advance the model over the next posedge
    task automatic run_cycle(input adc_sample_t s, input logic sync, input logic wr,
                             input cfg_addr_e addr, input logic [15:0] data);
        adc_out_t   e;
        logic [3:0] stb;
        @(negedge clk_adder);
        check_out(adc_out, exp_out.pop_front());
        check_bit("collision", collision, exp_coll.pop_front());
        check_bit("en_sync_out", en_sync_out, m_q2);
        sample     = s;
        en_sync_in = sync;
        cfg_wr     = wr;
        cfg_addr   = addr;
        cfg_wdata  = data;
        // a slice samples when its running counter wraps
        for (int i = 0; i < 4; i++) begin
            stb[i] = m_q2 & m_en[i] & ~m_on[i] & (m_cnt[i] == 2'd3);
        end
        e = '0;
        for (int i = 3; i >= 0; i--) begin
            if (stb[i]) begin
                e.valid  = 1'b1;
                e.idx    = 2'(i);
                e.result = expected_result(s, m_gain[i]);
            end
        end
        exp_out.push_back(e);
        exp_coll.push_back($countones(stb) > 1);
        for (int i = 0; i < 4; i++) begin
            if (!(m_q2 & m_en[i])) begin
                m_cnt[i] = m_phase[i];
            end else if (m_on[i]) begin
                m_cnt[i] = 2'd3;
            end else begin
                m_cnt[i] = m_cnt[i] + 2'd1;
            end
        end
        m_q2 = m_q1;
        m_q1 = sync;
        if (wr) begin
            case (addr)
                CFG_CTRL: begin
                    m_en = data[3:0];
                    m_on = data[7:4];
                end
                CFG_PHASE: m_phase = data[7:0];
                CFG_GAIN0: m_gain[0] = data[7:0];
                CFG_GAIN1: m_gain[1] = data[7:0];
                CFG_GAIN2: m_gain[2] = data[7:0];
                CFG_GAIN3: m_gain[3] = data[7:0];
                default: m_en = m_en;
            endcase
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        adc_sample_t s;
        void'($urandom(66));
        rstb       = 1'b0;
        sample     = '0;
        en_sync_in = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = CFG_CTRL;
        cfg_wdata  = '0;
        m_en       = '0;
        m_on       = '0;
        m_q1       = 1'b0;
        m_q2       = 1'b0;
        // counters already hold init after the first clock with sync low
        for (int i = 0; i < 4; i++) begin
            m_phase[i] = 2'(i);
            m_gain[i]  = 8'd64;
            m_cnt[i]   = 2'(i);
        end
        repeat (10) begin
            @(negedge clk_adder);
            check_bit("adc_out.valid", adc_out.valid, 1'b0);
            check_bit("collision", collision, 1'b0);
            check_bit("en_sync_out", en_sync_out, 1'b0);
        end
        rstb = 1'b1;
        repeat (3) begin
            exp_out.push_back('0);
            exp_coll.push_back(1'b0);
        end
        // sync dropped while the six registers are written, so phases reload
        for (int t = 0; t < N_ENTRY; t++) begin
            for (int k = 0; k < STIM[t].count; k++) begin
                s = STIM[t].rnd ? random_sample() : fixed_sample(k);
                if (k < 6) begin
                    run_cycle(s, 1'b0, 1'b1, cfg_addr_e'(3'(k)), write_data(STIM[t], k));
                end else begin
                    run_cycle(s, 1'b1, 1'b0, CFG_CTRL, 16'h0000);
                end
            end
        end
        repeat (3) begin
            run_cycle('0, 1'b1, 1'b0, CFG_CTRL, 16'h0000);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #((total_samples() + 50) * CLK_PERIOD);
        $display("Error: watchdog timeout, the run did not reach its end");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- tb/ti_adc_props.sv
// concurrent checks on collision, sync echo latency and strobe to output latency
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module ti_adc_props import adc_pkg::*; (
    input logic                   clk_adder,
    input logic                   rstb,
    input logic                   en_sync_in,
    input logic                   en_sync_out,
    input logic [`ADC_NSLICE-1:0] sample_stb,
    input adc_out_t               adc_out,
    input logic                   collision
);

    // a collision always comes with an output word
    a_coll_valid: assert property (@(posedge clk_adder) disable iff (!rstb)
        collision |-> adc_out.valid)
        else $error("collision without adc_out.valid");

    // two-flop synchronizer latency
    a_sync_echo: assert property (@(posedge clk_adder) disable iff (!rstb)
        en_sync_out == $past(en_sync_in, 2))
        else $error("en_sync_out does not follow en_sync_in by two cycles");

    // output word three cycles after any slice strobe
    a_out_latency: assert property (@(posedge clk_adder) disable iff (!rstb)
        adc_out.valid == $past(|sample_stb, 3))
        else $error("adc_out.valid does not follow a sample strobe by three cycles");

endmodule

bind ti_adc_top ti_adc_props u_ti_adc_props (
    .clk_adder   (clk_adder),
    .rstb        (rstb),
    .en_sync_in  (en_sync_in),
    .en_sync_out (en_sync_out),
    .sample_stb  (sample_stb),
    .adc_out     (adc_out),
    .collision   (collision)
);

`default_nettype wire

//--- hw/ti_adc_top.sv
// top level with config registers, four sync and quantizer slices and the output merge
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module ti_adc_top import adc_pkg::*; (
    input  logic        clk_adder,
    input  logic        rstb,
    input  adc_sample_t sample,
    input  logic        en_sync_in,
    input  logic        cfg_wr,
    input  cfg_addr_e   cfg_addr,
    input  logic [15:0] cfg_wdata,
    output logic        en_sync_out,
    output adc_out_t    adc_out,
    output logic        collision
);

    slice_cfg_t    [`ADC_NSLICE-1:0] slice_cfg;
    logic          [`ADC_NSLICE-1:0] sample_stb;
    logic          [`ADC_NSLICE-1:0] res_valid;
    slice_result_t [`ADC_NSLICE-1:0] results;

    adc_cfg_regs u_adc_cfg_regs (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .slice_cfg (slice_cfg)
    );

    //////////////////////////////
    // slices
    //////////////////////////////

    for (genvar g = 0; g < `ADC_NSLICE; g++) begin : g_slice
        // only slice 0 echoes the sync
        if (g == 0) begin : g_echo
            slice_sync u_slice_sync (
                .clk_adder   (clk_adder),
                .rstb        (rstb),
                .en_sync_in  (en_sync_in),
                .cfg         (slice_cfg[g]),
                .en_sync_out (en_sync_out),
                .sample_stb  (sample_stb[g])
            );
        end else begin : g_noecho
            slice_sync u_slice_sync (
                .clk_adder   (clk_adder),
                .rstb        (rstb),
                .en_sync_in  (en_sync_in),
                .cfg         (slice_cfg[g]),
                .en_sync_out (),
                .sample_stb  (sample_stb[g])
            );
        end

        slice_quantizer u_slice_quantizer (
            .clk_adder  (clk_adder),
            .rstb       (rstb),
            .sample_stb (sample_stb[g]),
            .sample     (sample),
            .gain       (slice_cfg[g].gain),
            .res_valid  (res_valid[g]),
            .result     (results[g])
        );
    end

    adc_output_merge u_adc_output_merge (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .res_valid (res_valid),
        .results   (results),
        .adc_out   (adc_out),
        .collision (collision)
    );

endmodule

`default_nettype wire

//--- hw/adc_output_merge.sv
// priority merge of slice results into one indexed stream, with collision flag
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module adc_output_merge import adc_pkg::*; (
    input  logic                              clk_adder,
    input  logic                              rstb,
    input  logic [`ADC_NSLICE-1:0]            res_valid,
    input  slice_result_t [`ADC_NSLICE-1:0]   results,
    output adc_out_t                          adc_out,
    output logic                              collision
);

    localparam int IW = $clog2(`ADC_NSLICE);

    logic          any_valid;
    logic          multi_valid;
    logic [IW-1:0] sel_idx;
    logic          valid_q;
    logic [IW-1:0] idx_q;
    slice_result_t res_q;

    // lowest index wins
    always_comb begin
        sel_idx = '0;
        for (int i = `ADC_NSLICE - 1; i >= 0; i--) begin
            if (res_valid[i]) begin
                sel_idx = IW'(i);
            end
        end
    end

    assign any_valid   = |res_valid;
    // clearing the lowest set bit leaves something when two or more are set
    assign multi_valid = |(res_valid & (res_valid - 1'b1));

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            valid_q   <= 1'b0;
            collision <= 1'b0;
        end else begin
            valid_q   <= any_valid;
            collision <= multi_valid;
        end
    end

    always_ff @(posedge clk_adder) begin
        if (any_valid) begin
            idx_q <= sel_idx;
            res_q <= results[sel_idx];
        end
    end

    always_comb begin
        adc_out.valid  = valid_q;
        adc_out.idx    = idx_q;
        adc_out.result = res_q;
    end

endmodule

`default_nettype wire

//--- hw/slice_quantizer.sv
// two-stage sign and difference, gain, shift and clamp pipeline for one slice
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module slice_quantizer import adc_pkg::*; (
    input  logic                   clk_adder,
    input  logic                   rstb,
    input  logic                   sample_stb,
    input  adc_sample_t            sample,
    input  logic [`ADC_GAIN_W-1:0] gain,
    output logic                   res_valid,
    output slice_result_t          result
);

    localparam int PROD_W = `ADC_NIN + `ADC_GAIN_W;
    localparam int SCL_W  = PROD_W - `ADC_GAIN_SHIFT;

    logic                 s1_valid;
    logic                 s1_sign;
    logic [`ADC_NIN-1:0]  s1_diff;
    logic [PROD_W-1:0]    prod;
    logic [SCL_W-1:0]     scaled;
    logic [`ADC_NMAG-1:0] mag_c;

    //////////////////////////////
    // stage 1, sign and |p - n|
    //////////////////////////////

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= sample_stb;
        end
    end

    always_ff @(posedge clk_adder) begin
        if (sample_stb) begin
            if (sample.vin_p >= sample.vin_n) begin
                s1_sign <= 1'b1;
                s1_diff <= sample.vin_p - sample.vin_n;
            end else begin
                s1_sign <= 1'b0;
                s1_diff <= sample.vin_n - sample.vin_p;
            end
        end
    end

    //////////////////////////////
    // stage 2, scale and clamp
    //////////////////////////////

    assign prod   = s1_diff * gain;
    assign scaled = prod[PROD_W-1:`ADC_GAIN_SHIFT];
    // saturate when anything lands above the magnitude bits
    assign mag_c  = (|scaled[SCL_W-1:`ADC_NMAG]) ? '1 : scaled[`ADC_NMAG-1:0];

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_adder) begin
        if (s1_valid) begin
            result.sign <= s1_sign;
            result.mag  <= mag_c;
        end
    end

endmodule

`default_nettype wire

//--- hw/slice_sync.sv
// sync input synchronizer with echo, loadable phase counter and sample strobe
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module slice_sync import adc_pkg::*; (
    input  logic       clk_adder,
    input  logic       rstb,
    input  logic       en_sync_in,
    input  slice_cfg_t cfg,
    output logic       en_sync_out,
    output logic       sample_stb
);

    logic                 sync_q1;
    logic                 sync_q2;
    logic                 local_sync;
    logic [`ADC_NDIV-1:0] count;

    //////////////////////////////
    // sync input
    //////////////////////////////

    // two-flop synchronizer, second stage is echoed
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= en_sync_in;
            sync_q2 <= sync_q1;
        end
    end

    assign en_sync_out = sync_q2;
    assign local_sync  = sync_q2 & cfg.enable;

    //////////////////////////////
    // phase counter
    //////////////////////////////

    // init load has priority over the always-on freeze
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            count <= '0;
        end else if (!local_sync) begin
            count <= cfg.init;
        end else if (cfg.always_on) begin
            count <= '1;
        end else begin
            count <= count + 1'b1;
        end
    end

    // rising edge of the divided clock, counter about to wrap
    assign sample_stb = local_sync & ~cfg.always_on & (count == '1);

endmodule

`default_nettype wire

//--- hw/adc_cfg_regs.sv
// write-only configuration registers feeding the per-slice control structs
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module adc_cfg_regs import adc_pkg::*; (
    input  logic                               clk_adder,
    input  logic                               rstb,
    input  logic                               cfg_wr,
    input  cfg_addr_e                          cfg_addr,
    input  logic [15:0]                        cfg_wdata,
    output slice_cfg_t [`ADC_NSLICE-1:0]       slice_cfg
);

    logic [`ADC_NSLICE-1:0]                    en_mask;
    logic [`ADC_NSLICE-1:0]                    on_mask;
    logic [`ADC_NSLICE-1:0][`ADC_NDIV-1:0]     phase;
    logic [`ADC_NSLICE-1:0][`ADC_GAIN_W-1:0]   gain;

    //////////////////////////////
    // register writes
    //////////////////////////////

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            en_mask <= '0;
            on_mask <= '0;
            // staggered phases, unity gain
            for (int i = 0; i < `ADC_NSLICE; i++) begin
                phase[i] <= `ADC_NDIV'(i);
                gain[i]  <= `ADC_GAIN_W'(1 << `ADC_GAIN_SHIFT);
            end
        end else if (cfg_wr) begin
            case (cfg_addr)
                CFG_CTRL: begin
                    en_mask <= cfg_wdata[3:0];
                    on_mask <= cfg_wdata[7:4];
                end
                CFG_PHASE: begin
                    // two bits per slice, slice 0 in the low bits
                    for (int i = 0; i < `ADC_NSLICE; i++) begin
                        phase[i] <= cfg_wdata[i*`ADC_NDIV +: `ADC_NDIV];
                    end
                end
                CFG_GAIN0: gain[0] <= cfg_wdata[`ADC_GAIN_W-1:0];
                CFG_GAIN1: gain[1] <= cfg_wdata[`ADC_GAIN_W-1:0];
                CFG_GAIN2: gain[2] <= cfg_wdata[`ADC_GAIN_W-1:0];
                CFG_GAIN3: gain[3] <= cfg_wdata[`ADC_GAIN_W-1:0];
                default: begin
                    // unmapped address, write ignored
                end
            endcase
        end
    end

    // one struct per slice
    always_comb begin
        for (int i = 0; i < `ADC_NSLICE; i++) begin
            slice_cfg[i].enable    = en_mask[i];
            slice_cfg[i].always_on = on_mask[i];
            slice_cfg[i].init      = phase[i];
            slice_cfg[i].gain      = gain[i];
        end
    end

endmodule

`default_nettype wire

//--- hw/adc_pkg.sv
// sample, slice config, slice result and output stream types, register address enum
`default_nettype none

`include "adc_defs.svh"

package adc_pkg;

    //////////////////////////////
    // datapath types
    //////////////////////////////

    // differential pair from the front end
    typedef struct packed {
        logic [`ADC_NIN-1:0] vin_p;
        logic [`ADC_NIN-1:0] vin_n;
    } adc_sample_t;

    // sign set when vin_p >= vin_n
    typedef struct packed {
        logic                 sign;
        logic [`ADC_NMAG-1:0] mag;
    } slice_result_t;

    // merged stream word
    typedef struct packed {
        logic                            valid;
        logic [$clog2(`ADC_NSLICE)-1:0]  idx;
        slice_result_t                   result;
    } adc_out_t;

    //////////////////////////////
    // configuration types
    //////////////////////////////

    typedef struct packed {
        logic                   enable;
        logic                   always_on;
        logic [`ADC_NDIV-1:0]   init;
        logic [`ADC_GAIN_W-1:0] gain;
    } slice_cfg_t;

    typedef enum logic [2:0] {
        CFG_CTRL  = 3'd0,
        CFG_PHASE = 3'd1,
        CFG_GAIN0 = 3'd2,
        CFG_GAIN1 = 3'd3,
        CFG_GAIN2 = 3'd4,
        CFG_GAIN3 = 3'd5
    } cfg_addr_e;

endpackage

`default_nettype wire

//--- hw/adc_defs.svh
// slice count, sample and magnitude widths, gain width and gain shift
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// number of interleaved slices
`define ADC_NSLICE 4

// divider counter width, one phase per slice
`define ADC_NDIV 2

// width of each digitized input sample
`define ADC_NIN 12

// output magnitude width, sign is carried separately
`define ADC_NMAG 7

// per-slice gain, unity at 1 << ADC_GAIN_SHIFT
`define ADC_GAIN_W 8
`define ADC_GAIN_SHIFT 6

`endif
